//--- mem_main_defines.svh
`ifndef MEM_MAIN_DEFINES_SVH
`define MEM_MAIN_DEFINES_SVH

// RT ports sharing the memory
`define NUM_RT 4

// Thread field at addr[16 +: THREAD_BITS], 6 in the full-size memory
`define THREAD_BITS 2
`define NUM_THREAD (1 << `THREAD_BITS)

// Word address at addr[2 +: WORD_BITS]
`define WORD_BITS 8
`define ROW_BITS (`WORD_BITS - 2)

`define NUM_BANK 4
`define LINE_BITS 128

`endif

//--- mem_main_pkg.sv
`include "mem_main_defines.svh"

package mem_main_pkg;

  typedef logic [31:0] word_t;
  typedef logic [`LINE_BITS-1:0] line_t;        // Word k at bits 32k upward
  typedef logic [`WORD_BITS-1:0] waddr_t;       // Word address inside a region
  typedef logic [$clog2(`NUM_RT)-1:0] port_idx_t;

  typedef struct packed {
    logic        we;
    logic        re;
    logic [31:0] addr;
    line_t       wdata;
  } rt_req_t;

  typedef struct packed {
    logic        re;
    logic [31:0] addr;
  } mc_req_t;

  // Winning command of one thread region
  typedef struct packed {
    logic   active;
    logic   we;
    waddr_t addr;                               // Start word of the line
    line_t  wdata;
  } bank_cmd_t;

  typedef struct packed {
    logic      valid;
    logic      is_mc;
    port_idx_t port;
    logic [1:0] rot;                            // Start word mod 4
  } grant_t;

endpackage

//--- mem_bank_ram.sv
`include "mem_main_defines.svh"

module mem_bank_ram
  import mem_main_pkg::*;
(
  input  logic                 clk,
  input  logic                 we,
  input  logic [`ROW_BITS-1:0] addr,
  input  word_t                din,
  output word_t                dout
);

  word_t mem [1 << `ROW_BITS];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= din;
    end
  end

  // Old data on a same-row write
  always_ff @(posedge clk) begin
    dout <= mem[addr];
  end

endmodule

//--- mem_port_arbiter.sv
`include "mem_main_defines.svh"

module mem_port_arbiter
  import mem_main_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  rt_req_t   rt_req   [`NUM_RT],
  input  mc_req_t   mc_req,
  output bank_cmd_t bank_cmd [`NUM_THREAD],
  output grant_t    grant    [`NUM_THREAD]
);

  function automatic logic [`THREAD_BITS-1:0] thread_of(input logic [31:0] addr);
    return addr[16 +: `THREAD_BITS];
  endfunction

  function automatic waddr_t word_of(input logic [31:0] addr);
    return addr[2 +: `WORD_BITS];
  endfunction

  for (genvar r = 0; r < `NUM_THREAD; r++) begin : g_region
    logic [`NUM_RT-1:0] rt_hit;
    logic               mc_hit;

    always_comb begin
      mc_hit = mc_req.re && (thread_of(mc_req.addr) == `THREAD_BITS'(r));
      for (int p = 0; p < `NUM_RT; p++) begin
        rt_hit[p] = (rt_req[p].we || rt_req[p].re) &&
                    (thread_of(rt_req[p].addr) == `THREAD_BITS'(r));
      end
    end

    always_comb begin
      logic found;
      found       = 1'b0;
      bank_cmd[r] = '0;
      grant[r]    = '0;
      if (mc_hit) begin                         // MC owns the region
        found              = 1'b1;
        bank_cmd[r].active = 1'b1;
        bank_cmd[r].addr   = word_of(mc_req.addr);
        grant[r].valid     = 1'b1;
        grant[r].is_mc     = 1'b1;
      end
      for (int p = 0; p < `NUM_RT; p++) begin
        if (rt_hit[p] && !found) begin          // Lowest index first
          found              = 1'b1;
          bank_cmd[r].active = 1'b1;
          bank_cmd[r].we     = rt_req[p].we;
          bank_cmd[r].addr   = word_of(rt_req[p].addr);
          bank_cmd[r].wdata  = rt_req[p].wdata;
          grant[r].valid     = 1'b1;
          grant[r].port      = port_idx_t'(p);
        end
      end
      grant[r].rot = bank_cmd[r].addr[1:0];
    end

    a_valid_winner: assert property (@(posedge clk) disable iff (!rst_n)
      (grant[r].valid == (mc_hit || (|rt_hit))) &&
      (grant[r].is_mc == mc_hit) &&
      (!grant[r].valid || grant[r].is_mc || rt_hit[grant[r].port]))
      else $error("region %0d grant does not match its requests", r);
  end

  for (genvar p = 0; p < `NUM_RT; p++) begin : g_port_chk
    a_no_we_re: assert property (@(posedge clk) disable iff (!rst_n)
      !(rt_req[p].we && rt_req[p].re))
      else $error("RT port %0d raised we and re together", p);
  end

endmodule

//--- mem_bank_group.sv
`include "mem_main_defines.svh"

module mem_bank_group
  import mem_main_pkg::*;
(
  input  logic      clk,
  input  bank_cmd_t bank_cmd,
  output line_t     rdata_banks               // Bank order, not line order
);

  logic bank_we;

  assign bank_we = bank_cmd.active && bank_cmd.we;

  for (genvar b = 0; b < `NUM_BANK; b++) begin : g_bank
    logic [1:0]           k;                  // Line word landing in bank b
    waddr_t               waddr;
    logic [`ROW_BITS-1:0] row;
    word_t                din;
    word_t                dout;

    assign k     = 2'(b) - bank_cmd.addr[1:0];
    assign waddr = bank_cmd.addr + `WORD_BITS'(k);   // Wraps at the top word
    assign row   = waddr[`WORD_BITS-1:2];
    assign din   = bank_cmd.wdata[k*32 +: 32];

    mem_bank_ram u_ram (
      .clk  (clk),
      .we   (bank_we),
      .addr (row),
      .din  (din),
      .dout (dout)
    );

    assign rdata_banks[b*32 +: 32] = dout;
  end

  a_we_active: assert property (@(posedge clk) bank_cmd.we |-> bank_cmd.active)
    else $error("bank write command without active flag");

endmodule

//--- mem_read_return.sv
`include "mem_main_defines.svh"

module mem_read_return
  import mem_main_pkg::*;
(
  input  logic               clk,
  input  logic               rst_n,
  input  grant_t             grant       [`NUM_THREAD],
  input  line_t              rdata_banks [`NUM_THREAD],
  output logic [`NUM_RT-1:0] rt_rdy,
  output line_t              rt_rdata    [`NUM_RT],
  output logic               mc_rdy,
  output line_t              mc_rdata
);

  grant_t                 grant_q [`NUM_THREAD];
  line_t                  line_q  [`NUM_THREAD];
  logic [`NUM_THREAD-1:0] rt_sel  [`NUM_RT];
  logic [`NUM_THREAD-1:0] mc_sel;

  // Grants line up with the registered bank reads
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int r = 0; r < `NUM_THREAD; r++) begin
        grant_q[r] <= '0;
      end
    end else begin
      grant_q <= grant;
    end
  end

  always_comb begin
    logic [1:0] bidx;
    for (int r = 0; r < `NUM_THREAD; r++) begin
      for (int k = 0; k < `NUM_BANK; k++) begin
        bidx = 2'(k) + grant_q[r].rot;          // Bank holding line word k
        line_q[r][k*32 +: 32] = rdata_banks[r][bidx*32 +: 32];
      end
    end
  end

  always_comb begin
    for (int r = 0; r < `NUM_THREAD; r++) begin
      mc_sel[r] = grant_q[r].valid && grant_q[r].is_mc;
      for (int p = 0; p < `NUM_RT; p++) begin
        rt_sel[p][r] = grant_q[r].valid && !grant_q[r].is_mc &&
                       (grant_q[r].port == port_idx_t'(p));
      end
    end
  end

  always_comb begin
    mc_rdy   = |mc_sel;
    mc_rdata = '0;
    for (int r = 0; r < `NUM_THREAD; r++) begin
      if (mc_sel[r]) begin
        mc_rdata = line_q[r];
      end
    end
    for (int p = 0; p < `NUM_RT; p++) begin
      rt_rdy[p]   = |rt_sel[p];
      rt_rdata[p] = '0;
      for (int r = 0; r < `NUM_THREAD; r++) begin
        if (rt_sel[p][r]) begin
          rt_rdata[p] = line_q[r];
        end
      end
    end
  end

  for (genvar p = 0; p < `NUM_RT; p++) begin : g_port_chk
    a_rt_one_src: assert property (@(posedge clk) disable iff (!rst_n)
      $onehot0(rt_sel[p]))
      else $error("RT port %0d granted by more than one region", p);
  end

  a_mc_one_src: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(mc_sel))
    else $error("MC port granted by more than one region");

endmodule

//--- mem_main.sv
`include "mem_main_defines.svh"

module mem_main
  import mem_main_pkg::*;
(
  input  logic               clk,
  input  logic               rst_n,
  input  rt_req_t            rt_req   [`NUM_RT],
  input  mc_req_t            mc_req,
  output logic [`NUM_RT-1:0] rt_rdy,
  output line_t              rt_rdata [`NUM_RT],
  output logic               mc_rdy,
  output line_t              mc_rdata
);

  bank_cmd_t bank_cmd    [`NUM_THREAD];
  grant_t    grant       [`NUM_THREAD];
  line_t     rdata_banks [`NUM_THREAD];

  mem_port_arbiter u_arbiter (
    .clk      (clk),
    .rst_n    (rst_n),
    .rt_req   (rt_req),
    .mc_req   (mc_req),
    .bank_cmd (bank_cmd),
    .grant    (grant)
  );

  // One group of four banks per thread region
  for (genvar t = 0; t < `NUM_THREAD; t++) begin : g_thread
    mem_bank_group u_group (
      .clk         (clk),
      .bank_cmd    (bank_cmd[t]),
      .rdata_banks (rdata_banks[t])
    );
  end

  mem_read_return u_return (
    .clk         (clk),
    .rst_n       (rst_n),
    .grant       (grant),
    .rdata_banks (rdata_banks),
    .rt_rdy      (rt_rdy),
    .rt_rdata    (rt_rdata),
    .mc_rdy      (mc_rdy),
    .mc_rdata    (mc_rdata)
  );

endmodule

//--- tb_mem_main.sv
`include "mem_main_defines.svh"

module tb_mem_main
  import mem_main_pkg::*;
();

  localparam int CLK_PERIOD       = 20;
  localparam int DRIVE_DLY        = 2;
  localparam int RESET_CYCLES     = 16;
  localparam int IDLE_CYCLES      = 10;
  localparam int LINE_WORDS       = `LINE_BITS / 32;
  localparam int PRELOAD_CYCLES   = (1 << `WORD_BITS) / LINE_WORDS;
  localparam int ALIGNED_CYCLES   = 10;
  localparam int UNALIGNED_ROUNDS = 32;
  localparam int DIRECTED_CYCLES  = 8;
  localparam int STREAM_CYCLES    = 400;
  localparam int MARGIN_CYCLES    = 100;
  localparam int TEST_CYCLES      = RESET_CYCLES + IDLE_CYCLES + PRELOAD_CYCLES +
                                    ALIGNED_CYCLES + 2 * UNALIGNED_ROUNDS +
                                    DIRECTED_CYCLES + STREAM_CYCLES + 3;

  logic               clk = 1'b0;
  logic               rst_n;
  rt_req_t            rt_req   [`NUM_RT];
  mc_req_t            mc_req;
  logic [`NUM_RT-1:0] rt_rdy;
  line_t              rt_rdata [`NUM_RT];
  logic               mc_rdy;
  line_t              mc_rdata;

  // Reference model state and expected responses for the next cycle
  word_t              model_mem [`NUM_THREAD][1 << `WORD_BITS];
  logic [`NUM_RT-1:0] exp_rt_rdy;
  logic [`NUM_RT-1:0] exp_rt_read;
  line_t              exp_rt_rdata [`NUM_RT];
  logic               exp_mc_rdy;
  line_t              exp_mc_rdata;

  logic [31:0] lfsr_state;
  int          rdy_errors  = 0;
  int          data_errors = 0;
  int          granted     = 0;
  int          read_checks = 0;

  mem_main u_dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .rt_req   (rt_req),
    .mc_req   (mc_req),
    .rt_rdy   (rt_rdy),
    .rt_rdata (rt_rdata),
    .mc_rdy   (mc_rdy),
    .mc_rdata (mc_rdata)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
  endtask

  task automatic rand_line(output line_t l);
    logic [31:0] w;
    for (int k = 0; k < LINE_WORDS; k++) begin
      take_bits(32, w);
      l[k*32 +: 32] = w;
    end
  endtask

  function automatic int region_of(input logic [31:0] addr);
    return int'(addr[16 +: `THREAD_BITS]);
  endfunction

  function automatic waddr_t start_word(input logic [31:0] addr);
    return addr[2 +: `WORD_BITS];
  endfunction

  function automatic logic [31:0] make_addr(input int r, input waddr_t w);
    return (32'(r) << 16) | (32'(w) << 2);
  endfunction

  // Preload value, unique per region and word
  function automatic line_t fill_line(input int r, input waddr_t a);
    line_t l;
    for (int k = 0; k < LINE_WORDS; k++) begin
      l[k*32 +: 32] = {8'ha5, 8'(r), 16'(waddr_t'(a + k))};
    end
    return l;
  endfunction

  function automatic line_t model_read(input int r, input waddr_t a);
    line_t l;
    for (int k = 0; k < LINE_WORDS; k++) begin
      l[k*32 +: 32] = model_mem[r][waddr_t'(a + k)];
    end
    return l;
  endfunction

  task automatic model_write(input int r, input waddr_t a, input line_t l);
    for (int k = 0; k < LINE_WORDS; k++) begin
      model_mem[r][waddr_t'(a + k)] = l[k*32 +: 32];
    end
  endtask

  task automatic clear_requests();
    for (int p = 0; p < `NUM_RT; p++) begin
      rt_req[p] = '0;
    end
    mc_req = '0;
  endtask

  // Hold the current requests for one cycle
  task automatic step();
    @(posedge clk);
    #DRIVE_DLY;
    clear_requests();
  endtask

  task automatic rt_write(input int p, input int r, input waddr_t w, input line_t d);
    rt_req[p].we    = 1'b1;
    rt_req[p].re    = 1'b0;
    rt_req[p].addr  = make_addr(r, w);
    rt_req[p].wdata = d;
  endtask

  task automatic rt_read(input int p, input int r, input waddr_t w);
    rt_req[p].we    = 1'b0;
    rt_req[p].re    = 1'b1;
    rt_req[p].addr  = make_addr(r, w);
    rt_req[p].wdata = '0;
  endtask

  task automatic mc_read(input int r, input waddr_t w);
    mc_req.re   = 1'b1;
    mc_req.addr = make_addr(r, w);
  endtask

  // MC first, then lowest RT port, per region
  always @(posedge clk) begin : ref_model
    logic [`NUM_RT-1:0] nxt_rdy;
    logic [`NUM_RT-1:0] nxt_read;
    line_t              nxt_data [`NUM_RT];
    logic               nxt_mc_rdy;
    line_t              nxt_mc_data;
    logic               taken;
    if (!rst_n) begin
      exp_rt_rdy  <= '0;
      exp_rt_read <= '0;
      exp_mc_rdy  <= 1'b0;
    end else begin
      nxt_rdy     = '0;
      nxt_read    = '0;
      nxt_mc_rdy  = 1'b0;
      nxt_mc_data = '0;
      for (int p = 0; p < `NUM_RT; p++) begin
        nxt_data[p] = '0;
      end
      for (int r = 0; r < `NUM_THREAD; r++) begin
        taken = mc_req.re && (region_of(mc_req.addr) == r);
        if (taken) begin
          nxt_mc_rdy  = 1'b1;
          nxt_mc_data = model_read(r, start_word(mc_req.addr));
          granted++;
          read_checks++;
        end
        for (int p = 0; p < `NUM_RT; p++) begin
          if (!taken && (rt_req[p].we || rt_req[p].re) &&
              (region_of(rt_req[p].addr) == r)) begin
            taken      = 1'b1;
            nxt_rdy[p] = 1'b1;
            granted++;
            if (rt_req[p].we) begin
              model_write(r, start_word(rt_req[p].addr), rt_req[p].wdata);
            end else begin
              nxt_read[p] = 1'b1;
              nxt_data[p] = model_read(r, start_word(rt_req[p].addr));
              read_checks++;
            end
          end
        end
      end
      exp_rt_rdy   <= nxt_rdy;
      exp_rt_read  <= nxt_read;
      exp_mc_rdy   <= nxt_mc_rdy;
      exp_mc_rdata <= nxt_mc_data;
      for (int p = 0; p < `NUM_RT; p++) begin
        exp_rt_rdata[p] <= nxt_data[p];
      end
    end
  end

  for (genvar p = 0; p < `NUM_RT; p++) begin : g_rt_chk
    a_rt_rdy: assert property (@(posedge clk) disable iff (!rst_n)
      rt_rdy[p] == exp_rt_rdy[p])
      else begin
        rdy_errors = rdy_errors + 1;
        $display("CHECK FAILED at %0t: RT port %0d rdy is %b, expected %b",
                 $time, p, $sampled(rt_rdy[p]), $sampled(exp_rt_rdy[p]));
      end

    a_rt_rdata: assert property (@(posedge clk) disable iff (!rst_n)
      exp_rt_read[p] |-> (rt_rdata[p] == exp_rt_rdata[p]))
      else begin
        data_errors = data_errors + 1;
        $display("CHECK FAILED at %0t: RT port %0d rdata %h, expected %h",
                 $time, p, $sampled(rt_rdata[p]), $sampled(exp_rt_rdata[p]));
      end
  end

  a_mc_rdy: assert property (@(posedge clk) disable iff (!rst_n)
    mc_rdy == exp_mc_rdy)
    else begin
      rdy_errors = rdy_errors + 1;
      $display("CHECK FAILED at %0t: MC rdy is %b, expected %b",
               $time, $sampled(mc_rdy), $sampled(exp_mc_rdy));
    end

  a_mc_rdata: assert property (@(posedge clk) disable iff (!rst_n)
    exp_mc_rdy |-> (mc_rdata == exp_mc_rdata))
    else begin
      data_errors = data_errors + 1;
      $display("CHECK FAILED at %0t: MC rdata %h, expected %h",
               $time, $sampled(mc_rdata), $sampled(exp_mc_rdata));
    end

  initial begin : watchdog
    #((TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
    $display("Timeout: the test sequence did not finish in %0d cycles",
             TEST_CYCLES + MARGIN_CYCLES);
    $display("Done: errors found");
    $finish;
  end

  initial begin : stimulus
    line_t       data;
    logic [31:0] op_bits;
    logic [31:0] port_bits;
    logic [31:0] reg_bits;
    logic [31:0] word_bits;
    int          port;
    lfsr_state = 32'hce94_fb6c;
    rst_n      = 1'b0;
    clear_requests();
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DLY;
    rst_n = 1'b1;

    repeat (IDLE_CYCLES) step();                // No requests, no rdy

    // Fill every region with aligned lines
    for (int row = 0; row < PRELOAD_CYCLES; row++) begin
      for (int r = 0; r < `NUM_THREAD; r++) begin
        rt_write(r % `NUM_RT, r, waddr_t'(row * LINE_WORDS),
                 fill_line(r, waddr_t'(row * LINE_WORDS)));
      end
      step();
    end

    for (int row = 0; row < ALIGNED_CYCLES - 2; row++) begin
      for (int r = 0; r < `NUM_THREAD; r++) begin
        rt_read((r + 1) % `NUM_RT, r, waddr_t'(row * LINE_WORDS));
      end
      step();
    end
    rand_line(data);
    rt_write(2, 3, waddr_t'(32), data);
    step();
    rt_read(0, 3, waddr_t'(32));
    step();

    repeat (UNALIGNED_ROUNDS) begin
      take_bits(2, port_bits);
      take_bits(`THREAD_BITS, reg_bits);
      take_bits(`WORD_BITS, word_bits);
      port = int'(port_bits) % `NUM_RT;
      rand_line(data);
      rt_write(port, int'(reg_bits), waddr_t'(word_bits), data);
      step();
      take_bits(2, op_bits);                    // Offset into the written line
      rt_read((port + 1) % `NUM_RT, int'(reg_bits), waddr_t'(word_bits + op_bits));
      step();
    end

    // Line at the top word wraps to word 0
    rand_line(data);
    rt_write(1, 0, '1, data);
    step();
    rt_read(3, 0, waddr_t'((1 << `WORD_BITS) - 3));
    mc_read(1, '1);
    step();
    rt_read(2, 0, '0);
    step();

    // Three writers in one region, port 1 wins
    for (int p = 1; p < `NUM_RT; p++) begin
      rand_line(data);
      rt_write(p, 2, waddr_t'(77), data);
    end
    step();
    rt_read(0, 2, waddr_t'(77));
    rt_read(3, 2, waddr_t'(77));
    step();

    // MC takes region 1, port 2 still served in region 3
    rand_line(data);
    mc_read(1, waddr_t'(17));
    rt_write(0, 1, waddr_t'(17), data);
    rt_read(1, 1, waddr_t'(19));
    rt_read(2, 3, waddr_t'(17));
    step();
    mc_read(1, waddr_t'(17));
    rt_read(3, 1, waddr_t'(16));
    step();
    step();

    repeat (STREAM_CYCLES) begin
      for (int p = 0; p < `NUM_RT; p++) begin
        take_bits(2, op_bits);
        take_bits(`THREAD_BITS, reg_bits);
        take_bits(`WORD_BITS, word_bits);
        if (op_bits[1]) begin
          rand_line(data);
          rt_write(p, int'(reg_bits), waddr_t'(word_bits), data);
        end else if (op_bits[0]) begin
          rt_read(p, int'(reg_bits), waddr_t'(word_bits));
        end
      end
      take_bits(1, op_bits);
      if (op_bits[0]) begin
        take_bits(`THREAD_BITS, reg_bits);
        take_bits(`WORD_BITS, word_bits);
        mc_read(int'(reg_bits), waddr_t'(word_bits));
      end
      step();
    end

    repeat (3) step();                          // Last responses reach the checks
    $display("Summary: %0d granted, %0d reads checked, %0d rdy errors, %0d data errors",
             granted, read_checks, rdy_errors, data_errors);
    if (rdy_errors + data_errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

//--- sources.f
+incdir+.
mem_main_pkg.sv
mem_bank_ram.sv
mem_port_arbiter.sv
mem_bank_group.sv
mem_read_return.sv
mem_main.sv
tb_mem_main.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the banked memory testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_mem_main -f sources.f -o sim_mem_main
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_mem_main 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qxF "Done: no errors"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1
